/* sim/lc3b_testdata.hex */
// word count, then program words from the reset PC, one per word address
// retire count, then pc wr dest data per retire (dest and data unused when wr is 0)
002A
1225 143D 1642 58C2 9ABF            // 0000 add imm, add, and, not
1B45 5D67 1D81                      // 000A dependent chain
D383 947F D6B2 D894 EA06            // 0010 lshf, not, rshfa, rshfl, lea
5020 0A05 0401 1261 14E0 0802 1261 1261 07FE // 001A br untaken and taken
EC03 C180 1261 1261                 // 002C lea, jmp
4804 EA03 4140 0E04 1261 1241 C1C0 1261 // 0034 jsr, jsrr, subroutine with ret
6200 7401 F025 2600                 // 0044 ldr, str, trap, ldb
1860 1903 E5D8 0FFF                 // 004C read back, lea backwards, loop
0026
0000 1 1 0005   0002 1 2 FFFD
0004 1 3 0002   0006 1 4 0000
0008 1 5 0002   000A 1 5 0004
000C 1 6 0004   000E 1 6 0009
0010 1 1 0048   0012 1 2 FFB7
0014 1 3 FFED   0016 1 4 0FFB
0018 1 5 0026   001A 1 0 0000
001C 0 0 0000   001E 0 0 0000
0022 1 2 FFED   0024 0 0 0000
002A 0 0 0000   002C 1 6 0034
002E 0 0 0000   0034 1 7 0036
003E 1 1 0090   0040 0 0 0000
0036 1 5 003E   0038 1 7 003A
003E 1 1 0120   0040 0 0 0000
003A 0 0 0000   0044 0 0 0000
0046 0 0 0000   0048 0 0 0000
004A 0 0 0000   004C 1 4 0120
004E 1 4 010D   0050 1 2 0002
0052 0 0 0000   0052 0 0 0000

/* src.f */
+incdir+logic
logic/lc3b_types.sv
logic/pipe_types.sv
logic/regfile.sv
logic/fetch.sv
logic/decode.sv
logic/execute.sv
logic/lc3b_core.sv
sim/tb_lc3b_core.sv

/* Bender.yml */
package:
  name: lc3b_core

sources:
  - include_dirs:
      - logic
    files:
      - logic/lc3b_types.sv
      - logic/pipe_types.sv
      - logic/regfile.sv
      - logic/fetch.sv
      - logic/decode.sv
      - logic/execute.sv
      - logic/lc3b_core.sv
  - target: test
    files:
      - sim/tb_lc3b_core.sv

/* sim/tb_lc3b_core.sv */
`timescale 1ns/10ps

module tb_lc3b_core;
	import lc3b_types::*;
	import pipe_types::*;

	localparam int tdata_words = 512;
	localparam int mem_words = 256;
	localparam int cycles_per_retire = 40;

	logic clk;
	logic arst_n;
	wb_req_t ibus_req;
	wb_rsp_t ibus_rsp;
	logic retire_valid;
	retire_t retire;

	logic [15:0] tdata [tdata_words]; // raw image of the data file
	lc3b_word mem [mem_words];
	int prog_len;
	int exp_base;
	int exp_count;
	int retired;
	logic busy;
	int ack_wait;
	logic [15:0] req_adr; // address of the open read

	lc3b_core i_lc3b_core (
		.clk,
		.arst_n,
		.ibus_req,
		.ibus_rsp,
		.retire_valid,
		.retire
	);

	always #2 clk = ~clk;

	task automatic abort_run();
		$display("FAIL: see errors above");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic report_mismatch(input string field, input logic [15:0] expected,
		input logic [15:0] actual);
		$display("[FAIL] %0t ns: retire %0d %s expected %h, got %h",
			$time, retired, field, expected, actual);
		abort_run();
	endtask

	task automatic protocol_error(input string what);
		$display("[FAIL] %0t ns: %s", $time, what);
		abort_run();
	endtask

	// compares one retire against the next expected entry, in program order
	task automatic check_retire();
		int base;
		logic exp_wr;
		base = exp_base + 4 * retired;
		exp_wr = tdata[base + 1][0];
		assert (retire.pc == tdata[base])
		else report_mismatch("pc", tdata[base], retire.pc);
		assert (retire.wr == exp_wr)
		else report_mismatch("wr", 16'(exp_wr), 16'(retire.wr));
		if (exp_wr) begin
			assert (retire.dest == tdata[base + 2][2:0])
			else report_mismatch("dest", tdata[base + 2], 16'(retire.dest));
			assert (retire.data == tdata[base + 3])
			else report_mismatch("data", tdata[base + 3], retire.data);
		end
		retired++;
		if (retired == exp_count) begin
			$display("PASS: all tests");
			$finish;
		end
	endtask

	initial begin
		void'($urandom(32'hf373_ff2d));
		clk = 1'b0;
		arst_n = 1'b0;
		ibus_rsp = '0;
		busy = 1'b0;
		ack_wait = 0;
		req_adr = '0;
		retired = 0;
		$readmemh("sim/lc3b_testdata.hex", tdata);
		prog_len = tdata[0];
		exp_count = tdata[prog_len + 1];
		exp_base = prog_len + 2;
		for (int i = 0; i < mem_words; i++)
			mem[i] = 16'(i); // BR with nzp clear, offset taken from the address
		for (int i = 0; i < prog_len; i++)
			mem[i] = tdata[i + 1];
		repeat (2) @(posedge clk);
		#0.5;
		arst_n = 1'b1;
	end

	// wishbone classic slave, one read at a time, ack after 1 to 4 cycles
	always @(posedge clk) begin
		#0.5;
		assert (ibus_req.cyc == ibus_req.stb)
		else protocol_error("cyc and stb differ on the instruction bus");
		if (ibus_rsp.ack) begin
			assert (!ibus_req.cyc)
			else protocol_error("cyc still high in the cycle after ack");
			ibus_rsp.ack = 1'b0; // single cycle ack
			busy = 1'b0;
		end else if (busy) begin
			assert (ibus_req.cyc && ibus_req.adr == req_adr)
			else protocol_error("read abandoned or address changed before ack");
			if (ack_wait <= 1) begin
				ibus_rsp.ack = 1'b1;
				ibus_rsp.dat = mem[ibus_req.adr[8:1]];
			end else begin
				ack_wait = ack_wait - 1;
			end
		end else if (ibus_req.cyc && ibus_req.stb) begin
			busy = 1'b1;
			req_adr = ibus_req.adr;
			ack_wait = 1 + int'($urandom % 4);
		end
	end

	always @(negedge clk) begin
		if (!arst_n) begin
			assert (!ibus_req.cyc && !ibus_req.stb && !retire_valid)
			else protocol_error("bus read or retire active during reset");
		end else if (retire_valid) begin
			check_retire();
		end
	end

	initial begin
		#1;
		repeat (exp_count * cycles_per_retire) @(posedge clk);
		$display("retirement stalled: %0d of %0d instructions retired in %0d cycles",
			retired, exp_count, exp_count * cycles_per_retire);
		abort_run();
	end

endmodule

/* logic/lc3b_core.sv */
`timescale 1ns/10ps

module lc3b_core (
	input logic clk,
	input logic arst_n,
	output pipe_types::wb_req_t ibus_req,
	input pipe_types::wb_rsp_t ibus_rsp,
	output logic retire_valid,
	output pipe_types::retire_t retire
);
	import lc3b_types::*;
	import pipe_types::*;

	IF_ID if_id;
	ID_EX id_ex;
	logic redirect;
	lc3b_word target;
	logic flush;
	logic wb_load;
	lc3b_reg wb_dest;
	lc3b_word wb_data;

	fetch i_fetch (
		.clk,
		.arst_n,
		.ibus_req,
		.ibus_rsp,
		.redirect,
		.target,
		.if_id
	);

	decode i_decode (
		.clk,
		.arst_n,
		.if_id,
		.flush,
		.wb_load,
		.wb_dest,
		.wb_data,
		.id_ex1(id_ex)
	);

	execute i_execute (
		.clk,
		.arst_n,
		.id_ex,
		.redirect,
		.target,
		.flush,
		.wb_load,
		.wb_dest,
		.wb_data,
		.retire_valid,
		.retire
	);

endmodule

/* logic/execute.sv */
`timescale 1ns/10ps

module execute (
	input logic clk,
	input logic arst_n,
	input pipe_types::ID_EX id_ex,
	output logic redirect,
	output lc3b_types::lc3b_word target,
	output logic flush,
	output logic wb_load,
	output lc3b_types::lc3b_reg wb_dest,
	output lc3b_types::lc3b_word wb_data,
	output logic retire_valid,
	output pipe_types::retire_t retire
);
	import lc3b_types::*;
	import pipe_types::*;

	lc3b_word srca;
	lc3b_word srcb;
	lc3b_word alu_out;
	lc3b_cc nzp;
	logic taken;

	assign srca = id_ex.ctrl.srcamux_sel ? id_ex.pc_out : id_ex.srca_out;

	always_comb begin
		case (id_ex.ctrl.srcbmux_sel)
			srcb_imm5: srcb = {{11{id_ex.intr[4]}}, id_ex.intr[4:0]};
			srcb_off9: srcb = {{6{id_ex.intr[8]}}, id_ex.intr[8:0], 1'b0};
			srcb_shamt: srcb = {12'b0, id_ex.intr[3:0]};
			srcb_off11: srcb = {{4{id_ex.intr[10]}}, id_ex.intr[10:0], 1'b0};
			default: srcb = id_ex.srcb_out;
		endcase
	end

	always_comb begin
		case (id_ex.ctrl.aluop)
			alu_and: alu_out = srca & srcb;
			alu_not: alu_out = ~srca;
			alu_pass: alu_out = srca;
			alu_sll: alu_out = srca << srcb[3:0];
			alu_srl: alu_out = srca >> srcb[3:0];
			alu_sra: alu_out = lc3b_word'($signed(srca) >>> srcb[3:0]);
			default: alu_out = srca + srcb;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			nzp <= 3'b010;
		else if (id_ex.valid && id_ex.ctrl.load_cc)
			nzp <= {alu_out[15], alu_out == '0, !alu_out[15] && alu_out != '0};
	end

	// BR tests the flags left by the previous instruction
	assign taken = id_ex.ctrl.is_br ? |(nzp & id_ex.intr[11:9])
		: (id_ex.ctrl.pcmux_sel != pc_next);

	assign redirect = id_ex.valid & taken;
	assign flush = redirect;
	assign target = (id_ex.ctrl.pcmux_sel == pc_reg) ? id_ex.srca_out : alu_out;

	assign wb_load = id_ex.valid & id_ex.ctrl.load_regfile;
	assign wb_dest = id_ex.dest;
	assign wb_data = id_ex.ctrl.destmux_sel ? id_ex.pc_out : alu_out; // link for JSR

	assign retire_valid = id_ex.valid;
	assign retire.pc = id_ex.pc_out - lc3b_word'(2);
	assign retire.wr = id_ex.ctrl.load_regfile;
	assign retire.dest = wb_dest;
	assign retire.data = wb_data;

endmodule

/* logic/decode.sv */
`timescale 1ns/10ps

module decode (
	input logic clk,
	input logic arst_n,
	input pipe_types::IF_ID if_id,
	input logic flush,
	input logic wb_load,
	input lc3b_types::lc3b_reg wb_dest,
	input lc3b_types::lc3b_word wb_data,
	output pipe_types::ID_EX id_ex1
);
	import lc3b_types::*;
	import pipe_types::*;

	lc3b_opcode opcode;
	lc3b_reg src_a;
	lc3b_reg src_b;
	lc3b_reg dest;
	lc3b_word reg_a;
	lc3b_word reg_b;
	ctrl_t ctrl;
	ID_EX id_ex;
	logic valid_q;

	assign opcode = lc3b_opcode'(if_id.intr[15:12]);
	assign src_a = if_id.intr[8:6];

	// stores name their data register in 11:9
	assign src_b = (opcode inside {op_str, op_stb, op_sti}) ? if_id.intr[11:9] : if_id.intr[2:0];
	assign dest = ctrl.destmux_sel ? 3'b111 : if_id.intr[11:9];

	regfile i_regfile (
		.clk,
		.arst_n,
		.load(wb_load),
		.in(wb_data),
		.dest(wb_dest),
		.src_a,
		.src_b,
		.reg_a,
		.reg_b
	);

	always_comb begin
		ctrl = '0;
		ctrl.srcbmux_sel = srcb_reg;
		ctrl.aluop = alu_add;
		ctrl.pcmux_sel = pc_next;
		case (opcode)
			op_add, op_and: begin
				ctrl.aluop = (opcode == op_and) ? alu_and : alu_add;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
				if (if_id.intr[5])
					ctrl.srcbmux_sel = srcb_imm5;
			end
			op_not: begin
				ctrl.aluop = alu_not;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end
			op_shf: begin
				ctrl.srcbmux_sel = srcb_shamt;
				if (!if_id.intr[4])
					ctrl.aluop = alu_sll;
				else if (if_id.intr[5])
					ctrl.aluop = alu_sra;
				else
					ctrl.aluop = alu_srl;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end
			op_lea: begin
				ctrl.srcamux_sel = 1'b1;
				ctrl.srcbmux_sel = srcb_off9;
				ctrl.load_regfile = 1'b1; // cc untouched in LC-3b
			end
			op_br: begin
				ctrl.srcamux_sel = 1'b1;
				ctrl.srcbmux_sel = srcb_off9;
				ctrl.pcmux_sel = pc_target;
				ctrl.is_br = 1'b1;
			end
			op_jmp: begin
				ctrl.aluop = alu_pass;
				ctrl.pcmux_sel = pc_reg;
			end
			op_jsr: begin
				ctrl.load_regfile = 1'b1;
				ctrl.destmux_sel = 1'b1;
				if (if_id.intr[11]) begin
					ctrl.srcamux_sel = 1'b1;
					ctrl.srcbmux_sel = srcb_off11;
					ctrl.pcmux_sel = pc_target;
				end else begin
					ctrl.aluop = alu_pass; // JSRR
					ctrl.pcmux_sel = pc_reg;
				end
			end
			default: ; // memory ops, rti and trap do nothing
		endcase
	end

	always_comb begin
		id_ex.valid = if_id.valid & ~flush;
		id_ex.ctrl = ctrl;
		id_ex.pc_out = if_id.pc_out;
		id_ex.intr = if_id.intr;
		id_ex.srca_out = (wb_load && wb_dest == src_a) ? wb_data : reg_a; // bypass writeback
		id_ex.srcb_out = (wb_load && wb_dest == src_b) ? wb_data : reg_b;
		id_ex.dest = dest;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			valid_q <= 1'b0;
		else
			valid_q <= id_ex.valid;
	end

	always_ff @(posedge clk) begin
		id_ex1.ctrl <= id_ex.ctrl;
		id_ex1.pc_out <= id_ex.pc_out;
		id_ex1.intr <= id_ex.intr;
		id_ex1.srca_out <= id_ex.srca_out;
		id_ex1.srcb_out <= id_ex.srcb_out;
		id_ex1.dest <= id_ex.dest;
	end

	assign id_ex1.valid = valid_q;

endmodule

/* logic/fetch.sv */
`timescale 1ns/10ps
`include "lc3b_settings.svh"

module fetch (
	input logic clk,
	input logic arst_n,
	output pipe_types::wb_req_t ibus_req,
	input pipe_types::wb_rsp_t ibus_rsp,
	input logic redirect,
	input lc3b_types::lc3b_word target,
	output pipe_types::IF_ID if_id
);
	import pipe_types::*;

	typedef enum logic [1:0] {
		idle,
		wait_ack,
		drop // read still open but its word is stale
	} fetch_state_t;

	fetch_state_t state;
	logic [15:0] pc;
	logic [15:0] pc_next;
	logic [15:0] pend_pc;
	logic if_valid;
	logic [15:0] if_pc;
	logic [15:0] if_intr;

	assign pc_next = pc + `LC3B_XLEN'(2);

	assign ibus_req.cyc = (state != idle);
	assign ibus_req.stb = (state != idle);
	assign ibus_req.adr = pc; // held for the whole read

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= idle;
			pc <= `LC3B_RESET_PC;
			if_valid <= 1'b0;
		end else begin
			if_valid <= 1'b0; // valid for a single cycle only
			case (state)
				idle: begin
					if (redirect)
						pc <= target;
					state <= wait_ack;
				end
				wait_ack: begin
					if (redirect) begin
						if (ibus_rsp.ack) begin
							pc <= target;
							state <= idle;
						end else begin
							state <= drop;
						end
					end else if (ibus_rsp.ack) begin
						if_valid <= 1'b1;
						pc <= pc_next;
						state <= idle;
					end
				end
				drop: begin
					if (ibus_rsp.ack) begin
						pc <= redirect ? target : pend_pc;
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == wait_ack && ibus_rsp.ack) begin
			if_pc <= pc_next;
			if_intr <= ibus_rsp.dat;
		end
		if (redirect)
			pend_pc <= target; // used once the open read ends
	end

	assign if_id = '{valid: if_valid, pc_out: if_pc, intr: if_intr};

endmodule

/* logic/regfile.sv */
`timescale 1ns/10ps
`include "lc3b_settings.svh"

module regfile (
	input logic clk,
	input logic arst_n,
	input logic load,
	input lc3b_types::lc3b_word in,
	input lc3b_types::lc3b_reg dest,
	input lc3b_types::lc3b_reg src_a,
	input lc3b_types::lc3b_reg src_b,
	output lc3b_types::lc3b_word reg_a,
	output lc3b_types::lc3b_word reg_b
);
	import lc3b_types::*;

	lc3b_word data [`LC3B_NREGS];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `LC3B_NREGS; i++)
				data[i] <= '0;
		end else if (load) begin
			data[dest] <= in;
		end
	end

	assign reg_a = data[src_a];
	assign reg_b = data[src_b];

endmodule

/* logic/pipe_types.sv */
package pipe_types;

	typedef enum logic [2:0] {
		srcb_reg,
		srcb_imm5,
		srcb_off9, // sext(offset9) << 1
		srcb_shamt,
		srcb_off11 // sext(offset11) << 1
	} srcb_sel_t;

	typedef enum logic [1:0] {
		pc_next,
		pc_target, // alu result
		pc_reg // base register
	} pc_sel_t;

	typedef struct packed {
		logic valid;
		lc3b_types::lc3b_word pc_out; // already incremented
		lc3b_types::lc3b_word intr;
	} IF_ID;

	typedef struct packed {
		logic srcamux_sel; // 1 selects pc_out
		srcb_sel_t srcbmux_sel;
		lc3b_types::alu_op_t aluop;
		logic load_regfile;
		logic load_cc;
		logic destmux_sel; // link into R7
		pc_sel_t pcmux_sel;
		logic is_br;
	} ctrl_t;

	typedef struct packed {
		logic valid;
		ctrl_t ctrl;
		lc3b_types::lc3b_word pc_out;
		lc3b_types::lc3b_word intr;
		lc3b_types::lc3b_word srca_out;
		lc3b_types::lc3b_word srcb_out;
		lc3b_types::lc3b_reg dest;
	} ID_EX;

	typedef struct packed {
		lc3b_types::lc3b_word pc;
		logic wr;
		lc3b_types::lc3b_reg dest;
		lc3b_types::lc3b_word data;
	} retire_t;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic [15:0] adr;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		logic [15:0] dat;
	} wb_rsp_t;

endpackage

/* logic/lc3b_types.sv */
`include "lc3b_settings.svh"

package lc3b_types;

	typedef logic [`LC3B_XLEN-1:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;
	typedef logic [2:0] lc3b_cc; // n, z, p

	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	typedef enum logic [2:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_pass, // srca straight through
		alu_sll,
		alu_srl,
		alu_sra
	} alu_op_t;

endpackage

/* logic/lc3b_settings.svh */
`ifndef LC3B_SETTINGS_SVH
`define LC3B_SETTINGS_SVH

// first instruction fetched after reset
`define LC3B_RESET_PC 16'h0000

// datapath width in bits
`define LC3B_XLEN 16

// architectural registers R0..R7
`define LC3B_NREGS 8

`endif
